/* hdl/buttonConditioner.sv */
`timescale 1ns/1ns

module buttonConditioner (
    input  logic clk,
    input  logic rst,
    input  logic button,
    output logic pressPulse
);

    // two flop synchronizer stages
    logic syncFf1;
    logic syncFf2;
    // synchronized level from the previous cycle
    logic history;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            syncFf1    <= 1'b0;
            syncFf2    <= 1'b0;
            history    <= 1'b0;
            pressPulse <= 1'b0;
        end else begin
            syncFf1 <= button;
            syncFf2 <= syncFf1;
            history <= syncFf2;
            // rising edge only, a held button gives one pulse
            pressPulse <= syncFf2 & ~history;
        end
    end

endmodule

/* hdl/displayPkg.sv */
package displayPkg;

    ////////////////////////////////////////////////////////////
    // overlay screen codes
    ////////////////////////////////////////////////////////////

    // values fixed by the video overlay decoder
    typedef enum logic [2:0] {
        scrBlank   = 3'd0,
        scrPlay    = 3'd1,
        scrLose    = 3'd2,
        scrWin     = 3'd3,
        scrLevelUp = 3'd4,
        scrWorldUp = 3'd5
    } screenT;

endpackage

/* hdl/gameFsm.sv */
`timescale 1ns/1ns
`include "game_defines.svh"

module gameFsm
    import gameStatePkg::*, displayPkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                startPress,
    input  logic                continuePress,
    input  logic                playerDead,
    input  logic                levelComplete,
    input  logic [`COUNT_W-1:0] level,
    input  logic [`COUNT_W-1:0] world,
    input  logic [`COUNT_W-1:0] lives,
    output logic                clearAll,
    output logic                levelAdvance,
    output logic                worldAdvance,
    output logic                lifeLose,
    output screenT              screenNext,
    output logic                playerEnable
);

    gameStateT state;
    gameStateT stateNext;

    // progression tests against the current counts
    logic lastLevel;
    logic lastWorld;
    logic lastLife;

    assign lastLevel = (level >= `COUNT_W'(`LEVEL_MAX - 1));
    assign lastWorld = (world >= `COUNT_W'(`WORLD_MAX - 1));
    assign lastLife  = (lives <  `COUNT_W'(2));

    ////////////////////////////////////////////////////////////
    // state register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= sTitle;
        end else begin
            state <= stateNext;
        end
    end

    ////////////////////////////////////////////////////////////
    // next state and outputs
    ////////////////////////////////////////////////////////////

    always_comb begin
        // defaults, hold state with all strobes idle
        stateNext    = state;
        clearAll     = 1'b0;
        levelAdvance = 1'b0;
        worldAdvance = 1'b0;
        lifeLose     = 1'b0;
        screenNext   = scrBlank;
        playerEnable = 1'b0;

        case (state)
            sTitle: begin
                // title overlay reuses the play code
                screenNext = scrPlay;
                if (startPress) begin
                    clearAll  = 1'b1;
                    stateNext = sPlay;
                end
            end
            sPlay: begin
                screenNext   = scrPlay;
                playerEnable = 1'b1;
                // death wins over a same cycle completion
                if (playerDead) begin
                    lifeLose  = 1'b1;
                    stateNext = lastLife ? sLose : sLifeLost;
                end else if (levelComplete) begin
                    if (!lastLevel) begin
                        levelAdvance = 1'b1;
                        stateNext    = sLevelUp;
                    end else if (!lastWorld) begin
                        // counter clears the level along with this
                        worldAdvance = 1'b1;
                        stateNext    = sWorldUp;
                    end else begin
                        stateNext = sWin;
                    end
                end
            end
            sLifeLost: begin
                // player keeps moving through the lost life
                screenNext   = scrPlay;
                playerEnable = 1'b1;
                stateNext    = sPlay;
            end
            sLevelUp: begin
                screenNext = scrLevelUp;
                if (continuePress) begin
                    stateNext = sPlay;
                end
            end
            sWorldUp: begin
                screenNext = scrWorldUp;
                if (continuePress) begin
                    stateNext = sPlay;
                end
            end
            sWin: begin
                screenNext = scrWin;
                if (continuePress) begin
                    // title shows start values again
                    clearAll  = 1'b1;
                    stateNext = sTitle;
                end
            end
            sLose: begin
                screenNext = scrLose;
                if (continuePress) begin
                    clearAll  = 1'b1;
                    stateNext = sTitle;
                end
            end
            default: begin
                stateNext = sTitle;
            end
        endcase
    end

endmodule

/* hdl/gameStatePkg.sv */
package gameStatePkg;

    ////////////////////////////////////////////////////////////
    // game flow states
    ////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        // waiting for start, counters held at start values
        sTitle,
        // normal gameplay
        sPlay,
        // single cycle after a lost life
        sLifeLost,
        // display states, left with continue
        sLevelUp,
        sWorldUp,
        sWin,
        sLose
    } gameStateT;

endpackage

/* hdl/gameTop.sv */
`timescale 1ns/1ns
`include "game_defines.svh"

module gameTop
    import displayPkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                startBtn,
    input  logic                continueBtn,
    input  logic                playerDead,
    input  logic                levelComplete,
    output screenT              screen,
    output logic [`COUNT_W-1:0] level,
    output logic [`COUNT_W-1:0] world,
    output logic [`COUNT_W-1:0] lives,
    output logic [`LED_W-1:0]   lifeLeds,
    output logic                playerEnable
);

    // button pulses
    logic   startPress;
    logic   continuePress;
    // counter strobes
    logic   clearAll;
    logic   levelAdvance;
    logic   worldAdvance;
    logic   lifeLose;
    screenT screenNext;

    ////////////////////////////////////////////////////////////
    // input side
    ////////////////////////////////////////////////////////////

    buttonConditioner startCond_i (
        .clk        (clk),
        .rst        (rst),
        .button     (startBtn),
        .pressPulse (startPress)
    );

    buttonConditioner continueCond_i (
        .clk        (clk),
        .rst        (rst),
        .button     (continueBtn),
        .pressPulse (continuePress)
    );

    ////////////////////////////////////////////////////////////
    // control and counts
    ////////////////////////////////////////////////////////////

    gameFsm gameFsm_i (
        .clk           (clk),
        .rst           (rst),
        .startPress    (startPress),
        .continuePress (continuePress),
        .playerDead    (playerDead),
        .levelComplete (levelComplete),
        .level         (level),
        .world         (world),
        .lives         (lives),
        .clearAll      (clearAll),
        .levelAdvance  (levelAdvance),
        .worldAdvance  (worldAdvance),
        .lifeLose      (lifeLose),
        .screenNext    (screenNext),
        .playerEnable  (playerEnable)
    );

    progressCounters progressCounters_i (
        .clk          (clk),
        .rst          (rst),
        .clearAll     (clearAll),
        .levelAdvance (levelAdvance),
        .worldAdvance (worldAdvance),
        .lifeLose     (lifeLose),
        .level        (level),
        .world        (world),
        .lives        (lives)
    );

    // output side
    statusDisplay statusDisplay_i (
        .clk        (clk),
        .rst        (rst),
        .screenNext (screenNext),
        .lives      (lives),
        .screen     (screen),
        .lifeLeds   (lifeLeds)
    );

endmodule

/* hdl/game_defines.svh */
`ifndef GAME_DEFINES_SVH
`define GAME_DEFINES_SVH

////////////////////////////////////////////////////////////
// game progression limits
////////////////////////////////////////////////////////////

// width of level, world and lives counts
`define COUNT_W 3

// levels per world, numbered from 0
`define LEVEL_MAX 5

// worlds per game, numbered from 0
`define WORLD_MAX 5

// lives given at the start of every game
`define START_LIVES 7

// one led per possible life
`define LED_W 7

`endif

/* hdl/progressCounters.sv */
`timescale 1ns/1ns
`include "game_defines.svh"

module progressCounters (
    input  logic                clk,
    input  logic                rst,
    input  logic                clearAll,
    input  logic                levelAdvance,
    input  logic                worldAdvance,
    input  logic                lifeLose,
    output logic [`COUNT_W-1:0] level,
    output logic [`COUNT_W-1:0] world,
    output logic [`COUNT_W-1:0] lives
);

    ////////////////////////////////////////////////////////////
    // level and world
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            level <= '0;
            world <= '0;
        end else if (clearAll) begin
            level <= '0;
            world <= '0;
        end else if (worldAdvance) begin
            // new world starts at its first level
            world <= world + `COUNT_W'(1);
            level <= '0;
        end else if (levelAdvance) begin
            level <= level + `COUNT_W'(1);
        end
    end

    ////////////////////////////////////////////////////////////
    // lives
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            lives <= `COUNT_W'(`START_LIVES);
        end else if (clearAll) begin
            lives <= `COUNT_W'(`START_LIVES);
        end else if (lifeLose && (lives != '0)) begin
            // saturate at zero
            lives <= lives - `COUNT_W'(1);
        end
    end

endmodule

/* hdl/statusDisplay.sv */
`timescale 1ns/1ns
`include "game_defines.svh"

module statusDisplay
    import displayPkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  screenT              screenNext,
    input  logic [`COUNT_W-1:0] lives,
    output screenT              screen,
    output logic [`LED_W-1:0]   lifeLeds
);

    // overlay code, blank until the first update
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            screen <= scrBlank;
        end else begin
            screen <= screenNext;
        end
    end

    ////////////////////////////////////////////////////////////
    // lives bar
    ////////////////////////////////////////////////////////////

    // thermometer, lowest leds lit first
    always_comb begin
        for (int i = 0; i < `LED_W; i++) begin
            lifeLeds[i] = (i < int'(lives));
        end
    end

endmodule

/* project.f */
+incdir+hdl
hdl/gameStatePkg.sv
hdl/displayPkg.sv
hdl/buttonConditioner.sv
hdl/progressCounters.sv
hdl/gameFsm.sv
hdl/statusDisplay.sv
hdl/gameTop.sv
tb/gameTopTb.sv

/* tb/gameTopTb.sv */
`timescale 1ns/1ns
`include "game_defines.svh"

module gameTopTb
    import displayPkg::*;
();

    typedef enum {actNone, actStart, actContinue, actDead, actComplete,
                  actHeldComplete} actionT;

    localparam int HOLD_CYCLES   = 4;
    localparam int SETTLE_CYCLES = 10;

    logic                clk;
    logic                rst;
    logic                startBtn;
    logic                continueBtn;
    logic                playerDead;
    logic                levelComplete;
    screenT              screen;
    logic [`COUNT_W-1:0] level;
    logic [`COUNT_W-1:0] world;
    logic [`COUNT_W-1:0] lives;
    logic [`LED_W-1:0]   lifeLeds;
    logic                playerEnable;

    // step table, one entry per index
    string               stepName[$];
    actionT              stepAction[$];
    screenT              stepScreen[$];
    logic [`COUNT_W-1:0] stepLevel[$];
    logic [`COUNT_W-1:0] stepWorld[$];
    logic [`COUNT_W-1:0] stepLives[$];
    logic                stepEnable[$];

    // expected counts while the table is built
    int expLevel;
    int expWorld;
    int expLives;
    bit tableReady;
    int numChecks;
    int numErrors;
    int curStep;

    gameTop gameTop_i (
        .clk           (clk),
        .rst           (rst),
        .startBtn      (startBtn),
        .continueBtn   (continueBtn),
        .playerDead    (playerDead),
        .levelComplete (levelComplete),
        .screen        (screen),
        .level         (level),
        .world         (world),
        .lives         (lives),
        .lifeLeds      (lifeLeds),
        .playerEnable  (playerEnable)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // table construction
    ////////////////////////////////////////////////////////////

    task automatic addStep(input string name, input actionT act, input screenT scr,
                           input logic enable);
        stepName.push_back(name);
        stepAction.push_back(act);
        stepScreen.push_back(scr);
        stepLevel.push_back(`COUNT_W'(expLevel));
        stepWorld.push_back(`COUNT_W'(expWorld));
        stepLives.push_back(`COUNT_W'(expLives));
        stepEnable.push_back(enable);
    endtask

    task automatic restoreCounts();
        expLevel = 0;
        expWorld = 0;
        expLives = `START_LIVES;
    endtask

    // next level, else next world, else win
    task automatic addCompletion();
        string name;
        name = $sformatf("complete at w%0d l%0d", expWorld, expLevel);
        if (expLevel < `LEVEL_MAX - 1) begin
            expLevel++;
            addStep(name, actComplete, scrLevelUp, 1'b0);
        end else if (expWorld < `WORLD_MAX - 1) begin
            expWorld++;
            expLevel = 0;
            addStep(name, actComplete, scrWorldUp, 1'b0);
        end else begin
            addStep(name, actComplete, scrWin, 1'b0);
        end
    endtask

    // continue still held from an earlier press, level up must stay
    task automatic addHeldCompletion();
        expLevel++;
        addStep("complete with continue held", actHeldComplete, scrLevelUp, 1'b0);
    endtask

    task automatic addContinue();
        addStep($sformatf("continue at w%0d l%0d", expWorld, expLevel), actContinue,
                scrPlay, 1'b1);
    endtask

    // last life ends the game, counter stops at zero
    task automatic addDeath();
        string name;
        name = $sformatf("dead with %0d lives", expLives);
        if (expLives >= 2) begin
            expLives--;
            addStep(name, actDead, scrPlay, 1'b1);
        end else begin
            expLives = 0;
            addStep(name, actDead, scrLose, 1'b0);
        end
    endtask

    task automatic buildTable();
        restoreCounts();
        addStep("after reset", actNone, scrPlay, 1'b0);
        addStep("start game", actStart, scrPlay, 1'b1);
        addDeath();
        addCompletion();
        addStep("dead on level up", actDead, scrLevelUp, 1'b0);
        addContinue();
        repeat (3) begin
            addCompletion();
            addContinue();
        end
        // fifth completion moves to world 1
        addCompletion();
        addStep("complete on world up", actComplete, scrWorldUp, 1'b0);
        addContinue();
        // first level of world 1
        addHeldCompletion();
        addContinue();
        while (expLives >= 2) addDeath();
        addDeath();
        addStep("complete on lose", actComplete, scrLose, 1'b0);
        restoreCounts();
        addStep("continue after lose", actContinue, scrPlay, 1'b0);
        addStep("start second game", actStart, scrPlay, 1'b1);
        repeat (`LEVEL_MAX * `WORLD_MAX - 1) begin
            addCompletion();
            addContinue();
        end
        addCompletion();
        addStep("dead on win", actDead, scrWin, 1'b0);
        restoreCounts();
        addStep("continue after win", actContinue, scrPlay, 1'b0);
        addStep("start fresh game", actStart, scrPlay, 1'b1);
        tableReady = 1'b1;
    endtask

    ////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////

    task automatic checkScreen(input string name, input screenT expected, input screenT actual);
        numChecks++;
        if (actual !== expected) begin
            numErrors++;
            $display("Mismatch %s screen: expected %s, actual %s (%0d)", name,
                     expected.name(), actual.name(), actual);
        end
    endtask

    task automatic checkCount(input string name, input string what,
                              input logic [`COUNT_W-1:0] expected,
                              input logic [`COUNT_W-1:0] actual);
        numChecks++;
        if (actual !== expected) begin
            numErrors++;
            $display("Mismatch %s %s: expected %0d, actual %0d", name, what, expected, actual);
        end
    endtask

    task automatic checkLeds(input string name, input logic [`LED_W-1:0] expected,
                             input logic [`LED_W-1:0] actual);
        numChecks++;
        if (actual !== expected) begin
            numErrors++;
            $display("Mismatch %s leds: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic checkBit(input string name, input string what, input logic expected,
                            input logic actual);
        numChecks++;
        if (actual !== expected) begin
            numErrors++;
            $display("Mismatch %s %s: expected %b, actual %b", name, what, expected, actual);
        end
    endtask

    // n lives light the n lowest leds
    function automatic logic [`LED_W-1:0] ledBar(input int n);
        logic [`LED_W:0] wide;
        wide = 1;
        wide = (wide << n) - 1;
        return wide[`LED_W-1:0];
    endfunction

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    // each cycle ends 1 ns after the rising edge
    task automatic waitCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic applyStep(input int idx);
        case (stepAction[idx])
            actStart:        startBtn = 1'b1;
            actContinue:     continueBtn = 1'b1;
            actHeldComplete: continueBtn = 1'b1;
            actDead:         playerDead = 1'b1;
            actComplete:     levelComplete = 1'b1;
            default:         ;
        endcase
        // buttons held, events one cycle
        if (stepAction[idx] == actStart || stepAction[idx] == actContinue) begin
            waitCycles(HOLD_CYCLES);
        end else if (stepAction[idx] == actHeldComplete) begin
            // press pulse already gone, button still down
            waitCycles(HOLD_CYCLES);
            levelComplete = 1'b1;
            waitCycles(1);
            levelComplete = 1'b0;
            waitCycles(1);
        end else if (stepAction[idx] != actNone) begin
            waitCycles(1);
        end
        startBtn      = 1'b0;
        continueBtn   = 1'b0;
        playerDead    = 1'b0;
        levelComplete = 1'b0;
        waitCycles(SETTLE_CYCLES);
        checkScreen(stepName[idx], stepScreen[idx], screen);
        checkCount(stepName[idx], "level", stepLevel[idx], level);
        checkCount(stepName[idx], "world", stepWorld[idx], world);
        checkCount(stepName[idx], "lives", stepLives[idx], lives);
        checkLeds(stepName[idx], ledBar(int'(stepLives[idx])), lifeLeds);
        checkBit(stepName[idx], "playerEnable", stepEnable[idx], playerEnable);
    endtask

    initial begin
        void'($urandom(32'h12fe_a88e));
        rst           = 1'b0;
        startBtn      = 1'b0;
        continueBtn   = 1'b0;
        playerDead    = 1'b0;
        levelComplete = 1'b0;
        numChecks     = 0;
        numErrors     = 0;
        curStep       = 0;
        buildTable();
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b1;
        for (curStep = 0; curStep < stepName.size(); curStep++) begin
            // idle gap of 0 to 3 cycles
            waitCycles($urandom % 4);
            applyStep(curStep);
        end
        $display("steps %0d, checks %0d, errors %0d", stepName.size(), numChecks, numErrors);
        if (numErrors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // longest step is under 20 cycles
    initial begin
        wait (tableReady);
        repeat (stepName.size() * 20 + 50) @(posedge clk);
        $display("watchdog expired at step %0d, the run did not finish in time", curStep);
        $display("Test FAILED");
        $finish;
    end

endmodule
